// ==== filelist.f ====
verilog/pmp_access_pkg.sv
verilog/pmp_cfg_pkg.sv
verilog/pmp_req_stage.sv
verilog/pmp_region_match.sv
verilog/pmp_resolve.sv
verilog/pmp_csr_file.sv
verilog/pmp_unit.sv
bench/pmp_unit_tb.sv

// ==== bench/pmp_unit_tb.sv ====
// Directed testbench for pmp_unit; the reference model assumes NUM_REGIONS 8 and GRANULARITY 2
`timescale 1ns/1ps

module pmp_unit_tb;

  localparam int NREG = 8;
  localparam int GRAN = 2;
  localparam int WAIT_LIMIT = 64;
  localparam int BP_COUNT = 40;
  localparam logic [11:0] CFG0  = pmp_cfg_pkg::CSR_PMPCFG_BASE;
  localparam logic [11:0] ADDR0 = pmp_cfg_pkg::CSR_PMPADDR_BASE;
  localparam logic [11:0] SEC   = pmp_cfg_pkg::CSR_MSECCFG;
  localparam pmp_cfg_pkg::csr_op_e OP_RD  = pmp_cfg_pkg::CSR_READ;
  localparam pmp_cfg_pkg::csr_op_e OP_WR  = pmp_cfg_pkg::CSR_WRITE;
  localparam pmp_cfg_pkg::csr_op_e OP_SET = pmp_cfg_pkg::CSR_SET;
  localparam pmp_cfg_pkg::csr_op_e OP_CLR = pmp_cfg_pkg::CSR_CLEAR;

  logic                     clk;
  logic                     rst_n;
  logic                     csr_valid;
  pmp_cfg_pkg::csr_req_t    csr_req;
  logic                     csr_rvalid;
  pmp_cfg_pkg::csr_rsp_t    csr_rsp;
  logic                     acc_valid;
  logic                     acc_ready;
  pmp_access_pkg::acc_req_t acc_req;
  logic                     rsp_valid;
  logic                     rsp_ready;
  pmp_access_pkg::acc_rsp_t rsp;

  int seed = 32'h3ea8e1d9;
  int errors = 0;
  int checks = 0;
  int tag_cnt = 0;

  // Reference register state
  pmp_cfg_pkg::pmp_cfg_t m_cfg [NREG];
  logic [31:0]           m_addr [NREG];
  logic                  m_rlb;

  pmp_unit #(
    .NUM_REGIONS (NREG),
    .GRANULARITY (GRAN)
  ) pmp_unit_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .csr_valid_i  (csr_valid),
    .csr_req_i    (csr_req),
    .csr_rvalid_o (csr_rvalid),
    .csr_rsp_o    (csr_rsp),
    .acc_valid_i  (acc_valid),
    .acc_ready_o  (acc_ready),
    .acc_req_i    (acc_req),
    .rsp_valid_o  (rsp_valid),
    .rsp_ready_i  (rsp_ready),
    .rsp_o        (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // NAPOT/NA4 show ones below G-1, OFF/TOR show zeros below G
  function automatic logic [31:0] model_addr_rb(int i);
    if (m_cfg[i].mode == pmp_cfg_pkg::MODE_NAPOT || m_cfg[i].mode == pmp_cfg_pkg::MODE_NA4) begin
      return m_addr[i] | ((32'd1 << (GRAN - 1)) - 32'd1);
    end
    return m_addr[i] & ~((32'd1 << GRAN) - 32'd1);
  endfunction

  function automatic logic [31:0] model_read(logic [11:0] a);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < NREG; i++) begin
      if (a == CFG0 + 12'(i / 4)) v[8 * (i % 4) +: 8] = m_cfg[i];
      if (a == ADDR0 + 12'(i)) v = model_addr_rb(i);
    end
    if (a == SEC) v[pmp_cfg_pkg::MSECCFG_RLB_BIT] = m_rlb;
    return v;
  endfunction

  function automatic void model_write(logic [11:0] a, logic [31:0] d);
    pmp_cfg_pkg::pmp_cfg_t nc;
    logic any_lock;
    logic frozen;
    any_lock = 1'b0;
    for (int i = 0; i < NREG; i++) any_lock |= m_cfg[i].lock;
    for (int i = 0; i < NREG; i++) begin
      if (a == CFG0 + 12'(i / 4) && !(m_cfg[i].lock && !m_rlb)) begin
        nc = d[8 * (i % 4) +: 8];
        // W without R is reserved
        if (nc.write && !nc.read) begin
          nc.exec  = m_cfg[i].exec;
          nc.write = m_cfg[i].write;
          nc.read  = m_cfg[i].read;
        end
        if (GRAN >= 1 && nc.mode == pmp_cfg_pkg::MODE_NA4) nc.mode = m_cfg[i].mode;
        nc.zero = 2'b00;
        m_cfg[i] = nc;
      end
      if (a == ADDR0 + 12'(i)) begin
        frozen = m_cfg[i].lock;
        if (i + 1 < NREG) begin
          frozen |= m_cfg[i+1].lock && m_cfg[i+1].mode == pmp_cfg_pkg::MODE_TOR;
        end
        if (!frozen || m_rlb) m_addr[i] = d;
      end
    end
    if (a == SEC && (m_rlb || !any_lock)) m_rlb = d[pmp_cfg_pkg::MSECCFG_RLB_BIT];
  endfunction

  function automatic pmp_access_pkg::acc_rsp_t model_check(pmp_access_pkg::acc_req_t r);
    pmp_access_pkg::acc_rsp_t e;
    logic [31:0] rb;
    logic [29:0] w;
    logic [29:0] a;
    logic [29:0] lo;
    logic [29:0] tmask;
    logic hit;
    logic perm;
    int t;
    e = '0;
    e.tag = r.tag;
    e.allowed = (r.priv == pmp_access_pkg::PRIV_M);
    w = r.addr[31:2];
    tmask = ~30'((1 << GRAN) - 1);
    for (int i = 0; i < NREG; i++) begin
      rb = model_addr_rb(i);
      a = rb[29:0];
      lo = 30'd0;
      if (i > 0) lo = m_addr[i-1][29:0];
      t = 0;
      while (t < 30 && a[t]) t++;
      case (m_cfg[i].mode)
        pmp_cfg_pkg::MODE_TOR:   hit = (w >= (lo & tmask)) && (w < (m_addr[i][29:0] & tmask));
        pmp_cfg_pkg::MODE_NA4:   hit = (w == a);
        pmp_cfg_pkg::MODE_NAPOT: hit = ((w >> (t + 1)) == (a >> (t + 1)));
        default:                 hit = 1'b0;
      endcase
      case (r.typ)
        pmp_access_pkg::ACC_EXEC:  perm = m_cfg[i].exec;
        pmp_access_pkg::ACC_WRITE: perm = m_cfg[i].write;
        default:                   perm = m_cfg[i].read;
      endcase
      if (r.priv == pmp_access_pkg::PRIV_M && !m_cfg[i].lock) perm = 1'b1;
      if (hit && !e.matched) begin
        e.matched = 1'b1;
        e.region = 4'(i);
        e.allowed = perm;
      end
    end
    return e;
  endfunction

  task automatic check_csr_rsp(pmp_cfg_pkg::csr_rsp_t got, pmp_cfg_pkg::csr_rsp_t exp,
                               string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, got rdata %h err %b, expected rdata %h err %b",
               $time, msg, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_acc_rsp(pmp_access_pkg::acc_rsp_t got, pmp_access_pkg::acc_rsp_t exp,
                               string msg);
    checks++;
    // Region index only counts on a match
    if (got.tag !== exp.tag || got.allowed !== exp.allowed || got.matched !== exp.matched ||
        (exp.matched && got.region !== exp.region)) begin
      errors++;
      $display("Fail at %0t: %s, got tag %0d allow %b match %b region %0d, expected %0d %b %b %0d",
               $time, msg, got.tag, got.allowed, got.matched, got.region,
               exp.tag, exp.allowed, exp.matched, exp.region);
    end
  endtask

  task automatic csr_xfer(pmp_cfg_pkg::csr_op_e op, logic [11:0] addr, logic [31:0] data,
                          pmp_access_pkg::priv_e priv, output pmp_cfg_pkg::csr_rsp_t got);
    int n;
    csr_valid     = 1'b1;
    csr_req.op    = op;
    csr_req.addr  = addr;
    csr_req.wdata = data;
    csr_req.priv  = priv;
    @(posedge clk);
    #2;
    csr_valid = 1'b0;
    n = 0;
    while (!csr_rvalid && n < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    got = csr_rsp;
    if (!csr_rvalid) begin
      errors++;
      $display("Timeout at %0t: no register response for address %h", $time, addr);
    end
  endtask

  // M-mode register operation checked against the model
  task automatic csr_op(pmp_cfg_pkg::csr_op_e op, logic [11:0] addr, logic [31:0] data);
    pmp_cfg_pkg::csr_rsp_t got;
    pmp_cfg_pkg::csr_rsp_t exp;
    logic [31:0] nw;
    exp.rdata = model_read(addr);
    exp.err = 1'b0;
    case (op)
      OP_SET:  nw = exp.rdata | data;
      OP_CLR:  nw = exp.rdata & ~data;
      default: nw = data;
    endcase
    csr_xfer(op, addr, data, pmp_access_pkg::PRIV_M, got);
    check_csr_rsp(got, exp, $sformatf("%s at %h", op.name(), addr));
    if (op != OP_RD) model_write(addr, nw);
  endtask

  task automatic acc_send(pmp_access_pkg::acc_req_t req);
    int n;
    logic done;
    acc_valid = 1'b1;
    acc_req = req;
    done = 1'b0;
    n = 0;
    while (!done && n < WAIT_LIMIT) begin
      @(negedge clk);
      done = acc_ready;
      @(posedge clk);
      #2;
      n++;
    end
    acc_valid = 1'b0;
    if (!done) begin
      errors++;
      $display("Timeout at %0t: request with tag %0d was never accepted", $time, req.tag);
    end
  endtask

  task automatic acc_recv(output pmp_access_pkg::acc_rsp_t got);
    int n;
    logic done;
    done = 1'b0;
    n = 0;
    got = '0;
    while (!done && n < WAIT_LIMIT) begin
      @(negedge clk);
      done = rsp_valid && rsp_ready;
      got = rsp;
      @(posedge clk);
      #2;
      n++;
    end
    if (!done) begin
      errors++;
      $display("Timeout at %0t: no access response arrived", $time);
    end
  endtask

  task automatic acc_check(logic [31:0] addr, pmp_access_pkg::acc_type_e typ,
                           pmp_access_pkg::priv_e priv, string msg);
    pmp_access_pkg::acc_req_t req;
    pmp_access_pkg::acc_rsp_t got;
    req.tag = 4'(tag_cnt);
    req.addr = addr;
    req.typ = typ;
    req.priv = priv;
    tag_cnt++;
    acc_send(req);
    acc_recv(got);
    check_acc_rsp(got, model_check(req), msg);
  endtask

  task automatic test_done(string name, int start);
    if (errors == start) $display("%s: passed", name);
    else $display("%s: %0d errors", name, errors - start);
  endtask

  task automatic test_reset();
    int start;
    start = errors;
    for (int i = 0; i < 4; i++) csr_op(OP_RD, CFG0 + 12'(i), 32'd0);
    for (int i = 0; i < 16; i++) csr_op(OP_RD, ADDR0 + 12'(i), 32'd0);
    csr_op(OP_RD, SEC, 32'd0);
    acc_check(32'h1000, pmp_access_pkg::ACC_READ, pmp_access_pkg::PRIV_U, "unmatched U read");
    acc_check(32'h1000, pmp_access_pkg::ACC_WRITE, pmp_access_pkg::PRIV_M, "unmatched M write");
    test_done("reset", start);
  endtask

  task automatic test_legalize();
    pmp_cfg_pkg::csr_rsp_t got;
    int start;
    start = errors;
    csr_op(OP_WR, CFG0, 32'h0000_0003);
    // Entry 0 asks for X and W without R, entry 1 turns TOR
    csr_op(OP_WR, CFG0, 32'h0000_0806);
    // Entry 1 asks for NA4, then sets its zero bits
    csr_op(OP_WR, CFG0, 32'h0000_1103);
    csr_op(OP_WR, CFG0, 32'h0000_6103);
    csr_op(OP_SET, CFG0, 32'h0004_0000);
    csr_op(OP_RD, CFG0, 32'd0);
    csr_xfer(OP_WR, CFG0, 32'd0, pmp_access_pkg::PRIV_U, got);
    check_csr_rsp(got, '{rdata: 32'd0, err: 1'b1}, "U-mode write");
    csr_xfer(OP_RD, 12'h7C0, 32'd0, pmp_access_pkg::PRIV_M, got);
    check_csr_rsp(got, '{rdata: 32'd0, err: 1'b1}, "unimplemented address");
    csr_op(OP_WR, CFG0, 32'd0);
    test_done("legalize", start);
  endtask

  task automatic test_readback();
    int start;
    start = errors;
    csr_op(OP_WR, ADDR0, 32'h0000_0402);
    csr_op(OP_WR, ADDR0 + 12'd1, 32'h0000_0803);
    csr_op(OP_WR, CFG0, 32'h0000_0019);
    csr_op(OP_RD, ADDR0, 32'd0);
    // Entry 0 OFF, entry 1 TOR
    csr_op(OP_WR, CFG0, 32'h0000_0900);
    csr_op(OP_RD, ADDR0, 32'd0);
    csr_op(OP_RD, ADDR0 + 12'd1, 32'd0);
    csr_op(OP_CLR, CFG0, 32'hffff_ffff);
    test_done("readback", start);
  endtask

  task automatic test_match();
    int start;
    start = errors;
    // TOR 0..0xfff RX, NAPOT 4 KiB at 0x2000 RW, NAPOT 16 KiB at 0 R
    csr_op(OP_WR, ADDR0, 32'h0000_0400);
    csr_op(OP_WR, ADDR0 + 12'd1, 32'h0000_09ff);
    csr_op(OP_WR, ADDR0 + 12'd2, 32'h0000_07ff);
    csr_op(OP_WR, CFG0, 32'h0019_1b0d);
    acc_check(32'h0100, pmp_access_pkg::ACC_EXEC, pmp_access_pkg::PRIV_U, "TOR exec");
    acc_check(32'h0100, pmp_access_pkg::ACC_WRITE, pmp_access_pkg::PRIV_U, "TOR write");
    acc_check(32'h2100, pmp_access_pkg::ACC_WRITE, pmp_access_pkg::PRIV_U, "overlap write");
    acc_check(32'h2100, pmp_access_pkg::ACC_EXEC, pmp_access_pkg::PRIV_U, "NAPOT exec");
    acc_check(32'h3000, pmp_access_pkg::ACC_READ, pmp_access_pkg::PRIV_U, "large NAPOT read");
    acc_check(32'h3000, pmp_access_pkg::ACC_WRITE, pmp_access_pkg::PRIV_U, "large NAPOT write");
    acc_check(32'h8000, pmp_access_pkg::ACC_READ, pmp_access_pkg::PRIV_U, "no region");
    acc_check(32'h0100, pmp_access_pkg::ACC_WRITE, pmp_access_pkg::PRIV_M, "M unlocked");
    csr_op(OP_WR, CFG0, 32'd0);
    test_done("match", start);
  endtask

  task automatic test_lock();
    int start;
    start = errors;
    csr_op(OP_WR, SEC, 32'h0000_0004);
    csr_op(OP_WR, ADDR0 + 12'd2, 32'h0000_0100);
    csr_op(OP_WR, ADDR0 + 12'd3, 32'h0000_0200);
    csr_op(OP_WR, CFG0, 32'h8900_0000);
    // RLB set, so the locked entry still takes writes
    csr_op(OP_WR, ADDR0 + 12'd3, 32'h0000_0240);
    csr_op(OP_WR, ADDR0 + 12'd2, 32'h0000_0140);
    csr_op(OP_WR, CFG0, 32'h8b00_0000);
    csr_op(OP_WR, CFG0, 32'h8900_0000);
    csr_op(OP_WR, SEC, 32'd0);
    csr_op(OP_SET, SEC, 32'h0000_0004);
    csr_op(OP_RD, SEC, 32'd0);
    csr_op(OP_WR, CFG0, 32'h0000_0100);
    csr_op(OP_RD, CFG0, 32'd0);
    csr_op(OP_WR, ADDR0 + 12'd3, 32'h0000_0300);
    csr_op(OP_WR, ADDR0 + 12'd2, 32'h0000_0180);
    csr_op(OP_WR, ADDR0 + 12'd1, 32'h0000_0050);
    csr_op(OP_RD, ADDR0 + 12'd2, 32'd0);
    csr_op(OP_RD, ADDR0 + 12'd3, 32'd0);
    acc_check(32'h0500, pmp_access_pkg::ACC_WRITE, pmp_access_pkg::PRIV_M, "locked M write");
    acc_check(32'h0500, pmp_access_pkg::ACC_READ, pmp_access_pkg::PRIV_M, "locked M read");
    acc_check(32'h0500, pmp_access_pkg::ACC_EXEC, pmp_access_pkg::PRIV_U, "locked U exec");
    test_done("lock", start);
  endtask

  task automatic test_backpressure();
    pmp_access_pkg::acc_req_t reqs [BP_COUNT];
    int gaps [BP_COUNT];
    pmp_access_pkg::acc_rsp_t expq [$];
    pmp_access_pkg::acc_rsp_t got;
    int start;
    int rcvd;
    int idle;
    logic take;
    start = errors;
    // Entry 0 NAPOT 1 KiB read-only next to the locked TOR entry
    csr_op(OP_WR, ADDR0, 32'h0000_007f);
    csr_op(OP_WR, CFG0, 32'h0000_0019);
    for (int i = 0; i < BP_COUNT; i++) begin
      reqs[i].tag = 4'(i);
      reqs[i].addr = $random(seed) & 32'h0000_0ffc;
      reqs[i].typ = pmp_access_pkg::acc_type_e'(2'($unsigned($random(seed)) % 3));
      reqs[i].priv = ($random(seed) & 1) ? pmp_access_pkg::PRIV_M : pmp_access_pkg::PRIV_U;
      gaps[i] = $unsigned($random(seed)) % 3;
      expq.push_back(model_check(reqs[i]));
    end
    rcvd = 0;
    idle = 0;
    fork
      begin
        for (int i = 0; i < BP_COUNT; i++) begin
          acc_send(reqs[i]);
          repeat (gaps[i]) begin
            @(posedge clk);
            #2;
          end
        end
      end
      begin
        while (rcvd < BP_COUNT && idle < WAIT_LIMIT) begin
          rsp_ready = 1'($random(seed) & 1);
          @(negedge clk);
          take = rsp_valid && rsp_ready;
          got = rsp;
          @(posedge clk);
          #2;
          if (take) begin
            check_acc_rsp(got, expq.pop_front(), $sformatf("response %0d", rcvd));
            rcvd++;
            idle = 0;
          end else begin
            idle++;
          end
        end
      end
    join
    rsp_ready = 1'b1;
    if (rcvd != BP_COUNT) begin
      errors++;
      $display("Timeout at %0t: only %0d of %0d responses came back", $time, rcvd, BP_COUNT);
    end
    test_done("backpressure", start);
  endtask

  initial begin
    for (int i = 0; i < NREG; i++) begin
      m_cfg[i] = '0;
      m_addr[i] = '0;
    end
    m_rlb = 1'b0;
    rst_n = 1'b0;
    csr_valid = 1'b0;
    csr_req = '0;
    acc_valid = 1'b0;
    acc_req = '0;
    rsp_ready = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset();
    test_legalize();
    test_readback();
    test_match();
    test_lock();
    test_backpressure();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/pmp_unit.sv ====
// PMP top level; NUM_REGIONS 1..16, GRANULARITY 0..8; two-cycle access check latency
`timescale 1ns/1ps

module pmp_unit #(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     csr_valid_i,
  input  pmp_cfg_pkg::csr_req_t    csr_req_i,
  output logic                     csr_rvalid_o,
  output pmp_cfg_pkg::csr_rsp_t    csr_rsp_o,
  input  logic                     acc_valid_i,
  output logic                     acc_ready_o,
  input  pmp_access_pkg::acc_req_t acc_req_i,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  output pmp_access_pkg::acc_rsp_t rsp_o
);

  pmp_cfg_pkg::pmp_cfg_t [NUM_REGIONS-1:0]        cfg;
  logic [NUM_REGIONS-1:0][31:0]                   pmp_addr;
  pmp_access_pkg::region_vote_t [NUM_REGIONS-1:0] votes;
  logic                                           stage_valid;
  pmp_access_pkg::acc_req_t                       stage_req;
  logic                                           advance;

  pmp_csr_file #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_csr_file (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_valid_i  (csr_valid_i),
    .csr_req_i    (csr_req_i),
    .csr_rvalid_o (csr_rvalid_o),
    .csr_rsp_o    (csr_rsp_o),
    .cfg_o        (cfg),
    .addr_o       (pmp_addr)
  );

  pmp_req_stage u_req_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .acc_valid_i   (acc_valid_i),
    .acc_ready_o   (acc_ready_o),
    .acc_req_i     (acc_req_i),
    .advance_i     (advance),
    .stage_valid_o (stage_valid),
    .stage_req_o   (stage_req)
  );

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_region
    logic [31:0] lower_addr;

    // TOR lower bound comes from the entry below
    if (i == 0) begin : gen_base
      assign lower_addr = 32'd0;
    end else begin : gen_prev
      assign lower_addr = pmp_addr[i-1];
    end

    pmp_region_match #(
      .GRANULARITY (GRANULARITY)
    ) u_match (
      .req_i        (stage_req),
      .cfg_i        (cfg[i]),
      .addr_i       (pmp_addr[i]),
      .lower_addr_i (lower_addr),
      .vote_o       (votes[i])
    );
  end

  pmp_resolve #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_resolve (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stage_valid_i (stage_valid),
    .stage_req_i   (stage_req),
    .votes_i       (votes),
    .advance_o     (advance),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_o         (rsp_o)
  );

endmodule

// ==== verilog/pmp_csr_file.sv ====
// All 16 entries are addressable, entries at or above NUM_REGIONS read zero; only mseccfg.RLB exists
`timescale 1ns/1ps

module pmp_csr_file #(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   csr_valid_i,
  input  pmp_cfg_pkg::csr_req_t                  csr_req_i,
  output logic                                   csr_rvalid_o,
  output pmp_cfg_pkg::csr_rsp_t                  csr_rsp_o,
  output pmp_cfg_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_o,
  output logic [NUM_REGIONS-1:0][31:0]           addr_o
);

  // Low pmpaddr bits hidden by the granularity
  localparam logic [31:0] ZERO_MASK = (32'd1 << GRANULARITY) - 32'd1;
  localparam logic [31:0] ONES_MASK = ZERO_MASK >> 1;

  pmp_cfg_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_q;
  pmp_cfg_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_d;
  logic [NUM_REGIONS-1:0][31:0]            addr_q;
  logic [NUM_REGIONS-1:0][31:0]            addr_d;
  logic                                    rlb_q;
  logic                                    rlb_d;
  logic [NUM_REGIONS-1:0]                  lock_vec;
  logic [NUM_REGIONS-1:0]                  tor_above;
  logic [NUM_REGIONS-1:0]                  addr_frozen;
  logic [11:0]                             cfg_off;
  logic [11:0]                             addr_off;
  logic                                    is_cfg;
  logic                                    is_addr;
  logic                                    is_sec;
  logic                                    err;
  logic                                    wr_en;
  logic [31:0]                             old_word;
  logic [31:0]                             new_word;
  logic                                    rvalid_q;
  pmp_cfg_pkg::csr_rsp_t                   rsp_q;

  // Refuse reserved encodings, then apply the lock
  function automatic pmp_cfg_pkg::pmp_cfg_t legalize_cfg(pmp_cfg_pkg::pmp_cfg_t old_cfg,
                                                         pmp_cfg_pkg::pmp_cfg_t req_cfg,
                                                         logic rlb);
    pmp_cfg_pkg::pmp_cfg_t cfg;
    cfg = req_cfg;
    // RW=01 is reserved
    if (req_cfg.write && !req_cfg.read) begin
      cfg.exec  = old_cfg.exec;
      cfg.write = old_cfg.write;
      cfg.read  = old_cfg.read;
    end
    if ((GRANULARITY >= 1) && (req_cfg.mode == pmp_cfg_pkg::MODE_NA4)) begin
      cfg.mode = old_cfg.mode;
    end
    if (old_cfg.lock && !rlb) begin
      cfg = old_cfg;
    end
    cfg.zero = 2'b00;
    return cfg;
  endfunction

  // Offsets below the base wrap to large values
  assign cfg_off  = csr_req_i.addr - pmp_cfg_pkg::CSR_PMPCFG_BASE;
  assign addr_off = csr_req_i.addr - pmp_cfg_pkg::CSR_PMPADDR_BASE;
  assign is_cfg   = cfg_off < 12'(pmp_cfg_pkg::MAX_REGIONS / 4);
  assign is_addr  = addr_off < 12'(pmp_cfg_pkg::MAX_REGIONS);
  assign is_sec   = csr_req_i.addr == pmp_cfg_pkg::CSR_MSECCFG;

  assign err   = !(is_cfg || is_addr || is_sec) || (csr_req_i.priv == pmp_access_pkg::PRIV_U);
  assign wr_en = csr_valid_i && !err && (csr_req_i.op != pmp_cfg_pkg::CSR_READ);

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_entry
    if (i < NUM_REGIONS - 1) begin : gen_above
      assign tor_above[i] = cfg_q[i+1].lock && (cfg_q[i+1].mode == pmp_cfg_pkg::MODE_TOR);
    end else begin : gen_top
      assign tor_above[i] = 1'b0;
    end
    assign lock_vec[i]    = cfg_q[i].lock;
    assign addr_frozen[i] = (cfg_q[i].lock || tor_above[i]) && !rlb_q;
    // NAPOT/NA4 read low bits as ones, OFF/TOR as zeros
    assign addr_o[i] = (cfg_q[i].mode inside {pmp_cfg_pkg::MODE_NA4, pmp_cfg_pkg::MODE_NAPOT}) ?
                       (addr_q[i] | ONES_MASK) : (addr_q[i] & ~ZERO_MASK);
  end

  assign cfg_o = cfg_q;

  // Current value of the addressed register
  always_comb begin
    old_word = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (is_cfg && (cfg_off[1:0] == 2'(i / 4))) begin
        old_word[8 * (i % 4) +: 8] = cfg_q[i];
      end
      if (is_addr && (addr_off[3:0] == 4'(i))) begin
        old_word = addr_o[i];
      end
    end
    if (is_sec) begin
      old_word[pmp_cfg_pkg::MSECCFG_RLB_BIT] = rlb_q;
    end
  end

  always_comb begin
    case (csr_req_i.op)
      pmp_cfg_pkg::CSR_SET:   new_word = old_word | csr_req_i.wdata;
      pmp_cfg_pkg::CSR_CLEAR: new_word = old_word & ~csr_req_i.wdata;
      default:                new_word = csr_req_i.wdata;
    endcase
  end

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    rlb_d  = rlb_q;
    if (wr_en) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (is_cfg && (cfg_off[1:0] == 2'(i / 4))) begin
          cfg_d[i] = legalize_cfg(cfg_q[i],
                                  pmp_cfg_pkg::pmp_cfg_t'(new_word[8 * (i % 4) +: 8]),
                                  rlb_q);
        end
        if (is_addr && (addr_off[3:0] == 4'(i)) && !addr_frozen[i]) begin
          addr_d[i] = new_word;
        end
      end
      // RLB is sticky-off once something is locked without it
      if (is_sec && (!(|lock_vec) || rlb_q)) begin
        rlb_d = new_word[pmp_cfg_pkg::MSECCFG_RLB_BIT];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q    <= '0;
      addr_q   <= '0;
      rlb_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      cfg_q    <= cfg_d;
      addr_q   <= addr_d;
      rlb_q    <= rlb_d;
      rvalid_q <= csr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csr_valid_i) begin
      rsp_q.rdata <= err ? 32'd0 : old_word;
      rsp_q.err   <= err;
    end
  end

  assign csr_rvalid_o = rvalid_q;
  assign csr_rsp_o    = rsp_q;

endmodule

// ==== verilog/pmp_resolve.sv ====
// Lowest-index region wins; no match allows M-mode and denies U-mode; NUM_REGIONS up to 16
`timescale 1ns/1ps

module pmp_resolve #(
  parameter int NUM_REGIONS = 8
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          stage_valid_i,
  input  pmp_access_pkg::acc_req_t                      stage_req_i,
  input  pmp_access_pkg::region_vote_t [NUM_REGIONS-1:0] votes_i,
  output logic                                          advance_o,
  output logic                                          rsp_valid_o,
  input  logic                                          rsp_ready_i,
  output pmp_access_pkg::acc_rsp_t                      rsp_o
);

  logic                     hit;
  logic [3:0]               hit_idx;
  logic                     hit_permit;
  pmp_access_pkg::acc_rsp_t result;
  logic                     rsp_valid_q;
  pmp_access_pkg::acc_rsp_t rsp_q;

  // Scan from the top so the lowest match is kept
  always_comb begin
    hit        = 1'b0;
    hit_idx    = 4'd0;
    hit_permit = 1'b0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (votes_i[i].match) begin
        hit        = 1'b1;
        hit_idx    = 4'(i);
        hit_permit = votes_i[i].permit;
      end
    end
  end

  always_comb begin
    result.tag     = stage_req_i.tag;
    result.matched = hit;
    result.region  = hit_idx;
    result.allowed = hit ? hit_permit : (stage_req_i.priv == pmp_access_pkg::PRIV_M);
  end

  // Result register frees up when empty or being taken
  assign advance_o = !rsp_valid_q || rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (advance_o) begin
      rsp_valid_q <= stage_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_o && stage_valid_i) begin
      rsp_q <= result;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== verilog/pmp_region_match.sv ====
// Combinational check of one region; only pmpaddr bits 29:0 are compared (32-bit physical space)
`timescale 1ns/1ps

module pmp_region_match #(
  parameter int GRANULARITY = 2
) (
  input  pmp_access_pkg::acc_req_t     req_i,
  input  pmp_cfg_pkg::pmp_cfg_t        cfg_i,
  input  logic [31:0]                  addr_i,
  input  logic [31:0]                  lower_addr_i,
  output pmp_access_pkg::region_vote_t vote_o
);

  // TOR bounds are aligned to the region granularity
  localparam logic [29:0] TOR_MASK = ~((30'd1 << GRANULARITY) - 30'd1);

  logic [29:0] word;
  logic [29:0] upper;
  logic [29:0] lower;
  logic [29:0] napot_care;
  logic        match;
  logic        perm;

  assign word  = req_i.addr[31:2];
  assign upper = addr_i[29:0] & TOR_MASK;
  assign lower = lower_addr_i[29:0] & TOR_MASK;

  // Trailing ones plus the next zero are don't-care bits
  assign napot_care = ~(addr_i[29:0] ^ (addr_i[29:0] + 30'd1));

  always_comb begin
    case (cfg_i.mode)
      pmp_cfg_pkg::MODE_TOR:   match = (word >= lower) && (word < upper);
      pmp_cfg_pkg::MODE_NA4:   match = (word == addr_i[29:0]);
      pmp_cfg_pkg::MODE_NAPOT: match = ((word ^ addr_i[29:0]) & napot_care) == 30'd0;
      default:                 match = 1'b0;
    endcase
  end

  always_comb begin
    case (req_i.typ)
      pmp_access_pkg::ACC_EXEC:  perm = cfg_i.exec;
      pmp_access_pkg::ACC_WRITE: perm = cfg_i.write;
      default:                   perm = cfg_i.read;
    endcase
  end

  assign vote_o.match = match;
  // M-mode is only bound by locked entries
  assign vote_o.permit = ((req_i.priv == pmp_access_pkg::PRIV_M) && !cfg_i.lock) ? 1'b1 : perm;

endmodule

// ==== verilog/pmp_req_stage.sv ====
// One-entry skid-free input register; requester must hold valid and data until accepted
`timescale 1ns/1ps

module pmp_req_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     acc_valid_i,
  output logic                     acc_ready_o,
  input  pmp_access_pkg::acc_req_t acc_req_i,
  input  logic                     advance_i,
  output logic                     stage_valid_o,
  output pmp_access_pkg::acc_req_t stage_req_o
);

  logic                     valid_q;
  pmp_access_pkg::acc_req_t req_q;

  // Room when empty or when the held item moves to the resolver
  assign acc_ready_o = !valid_q || advance_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (acc_ready_o) begin
      valid_q <= acc_valid_i;
    end
  end

  // Payload only loads on a handshake
  always_ff @(posedge clk_i) begin
    if (acc_valid_i && acc_ready_o) begin
      req_q <= acc_req_i;
    end
  end

  assign stage_valid_o = valid_q;
  assign stage_req_o   = req_q;

endmodule

// ==== verilog/pmp_cfg_pkg.sv ====
// PMP register types and register-port protocol; compile after pmp_access_pkg (uses priv_e)
package pmp_cfg_pkg;

  // Address-matching mode of one region
  typedef enum logic [1:0] {
    MODE_OFF   = 2'd0,
    MODE_TOR   = 2'd1,
    MODE_NA4   = 2'd2,
    MODE_NAPOT = 2'd3
  } pmp_mode_e;

  // One cfg byte, same layout as a pmpcfg field
  typedef struct packed {
    logic       lock;
    logic [1:0] zero;
    pmp_mode_e  mode;
    logic       exec;
    logic       write;
    logic       read;
  } pmp_cfg_t;

  // Register operations, CSRRW/CSRRS/CSRRC style
  typedef enum logic [1:0] {
    CSR_READ  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_e;

  typedef struct packed {
    csr_op_e                 op;
    logic [11:0]             addr;
    logic [31:0]             wdata;
    pmp_access_pkg::priv_e   priv;
  } csr_req_t;

  // rdata is the value before the operation
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } csr_rsp_t;

  // Register map
  localparam logic [11:0] CSR_PMPCFG_BASE  = 12'h3A0;
  localparam logic [11:0] CSR_PMPADDR_BASE = 12'h3B0;
  localparam logic [11:0] CSR_MSECCFG      = 12'h747;

  localparam int MSECCFG_RLB_BIT = 2;

  // Architectural limit, decides which register addresses exist
  localparam int MAX_REGIONS = 16;

endpackage

// ==== verilog/pmp_access_pkg.sv ====
// Access-side types; priv_e uses the ISA encoding and only U and M are supported
package pmp_access_pkg;

  // Privilege of the requester, ISA encoding
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    ACC_EXEC  = 2'd0,
    ACC_READ  = 2'd1,
    ACC_WRITE = 2'd2
  } acc_type_e;

  typedef struct packed {
    logic [3:0]  tag;
    logic [31:0] addr;
    acc_type_e   typ;
    priv_e       priv;
  } acc_req_t;

  // Region index is only meaningful when matched is set
  typedef struct packed {
    logic [3:0] tag;
    logic       allowed;
    logic       matched;
    logic [3:0] region;
  } acc_rsp_t;

  // Verdict of a single region matcher
  typedef struct packed {
    logic match;
    logic permit;
  } region_vote_t;

endpackage
